// ==== design/dev_table.sv ====
// ==================================================
// Device table
// Read-only slave listing the id and the map size of
// every bus region, two words per entry.
// ==================================================
`timescale 1ns/10ps

module dev_table import soc_pkg::*; (
	 input  logic    clk100mhz_i
	,input  logic    rst_p
	,input  pi1_op_t op_i
	,input  addr_t   addr_i
	,output data_t   rdata_o
	,output logic    rdy_o
);

	localparam int IDX_BITS = $clog2(DEVTBL_WORDS);

	logic [IDX_BITS-1:0] word;
	logic [IDX_BITS-2:0] entry;
	data_t               entry_word;
	data_t               rdata_q;
	logic                rdy_q;
	logic                req;

	assign req   = (op_i != PI1_NOP) && !rdy_q;
	assign word  = addr_i[IDX_BITS-1:0];
	assign entry = word[IDX_BITS-1:1];

	// Even word holds the id, odd word the map size.
	always_comb begin
		if (entry < SLAVE_COUNT) begin
			if (word[0])
				entry_word = dev_mapsz(slave_e'(entry[2:0]));
			else
				entry_word = dev_id(slave_e'(entry[2:0]));
		end else begin
			entry_word = '0;
		end
	end

	// Writes still get a response but change nothing.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= req;
	end

	always_ff @(posedge clk100mhz_i) begin
		if (req && op_i == PI1_RD)
			rdata_q <= entry_word;
	end

	assign rdata_o = rdata_q;
	assign rdy_o   = rdy_q;

endmodule

// ==== design/dma_engine.sv ====
// ==================================================
// DMA engine
// Register slave for source, destination, length and
// status, and a bus master that copies one word per
// read/write pair until the length runs out.
// ==================================================
`timescale 1ns/10ps

module dma_engine import soc_pkg::*; #(
	parameter int DMA_LEN_BITS = 16
) (
	 input  logic    clk100mhz_i
	,input  logic    rst_p
	,input  pi1_op_t s_op_i
	,input  addr_t   s_addr_i
	,input  data_t   s_wdata_i
	,output data_t   s_rdata_o
	,output logic    s_rdy_o
	,output pi1_op_t m_op_o
	,output addr_t   m_addr_o
	,output data_t   m_wdata_o
	,output sel_t    m_sel_o
	,input  data_t   m_rdata_i
	,input  logic    m_rdy_i
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_RD   = 2'd1;
	localparam logic [1:0] ST_WR   = 2'd2;

	logic [1:0]              state_q;
	addr_t                   src_q;
	addr_t                   dst_q;
	logic [DMA_LEN_BITS-1:0] len_q;
	data_t                   buf_q;
	data_t                   rdata_q;
	logic                    rdy_q;
	logic                    busy;
	logic                    s_req;

	assign busy  = (state_q != ST_IDLE);
	assign s_req = (s_op_i != PI1_NOP) && !rdy_q;

	// Register port; the held op is ignored during the rdy cycle.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= s_req;
	end

	always_ff @(posedge clk100mhz_i) begin
		if (s_req && s_op_i == PI1_RD) begin
			case (s_addr_i[1:0])
				2'd0:    rdata_q <= data_t'(src_q);
				2'd1:    rdata_q <= data_t'(dst_q);
				2'd2:    rdata_q <= data_t'(len_q);
				default: rdata_q <= data_t'(busy);
			endcase
		end
	end

	assign s_rdata_o = rdata_q;
	assign s_rdy_o   = rdy_q;

	// Copy FSM. Configuration writes only land while idle.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			state_q <= ST_IDLE;
			src_q   <= '0;
			dst_q   <= '0;
			len_q   <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (s_req && s_op_i == PI1_WR) begin
						case (s_addr_i[1:0])
							2'd0: src_q <= addr_t'(s_wdata_i);
							2'd1: dst_q <= addr_t'(s_wdata_i);
							2'd2: begin
								len_q <= s_wdata_i[DMA_LEN_BITS-1:0];
								if (s_wdata_i[DMA_LEN_BITS-1:0] != '0)
									state_q <= ST_RD;
							end
							default: ;
						endcase
					end
				end
				ST_RD: begin
					if (m_rdy_i) begin
						src_q   <= src_q + 1'b1;
						state_q <= ST_WR;
					end
				end
				default: begin
					if (m_rdy_i) begin
						dst_q <= dst_q + 1'b1;
						len_q <= len_q - 1'b1;
						// Last word done.
						state_q <= (len_q == 1) ? ST_IDLE : ST_RD;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (state_q == ST_RD && m_rdy_i)
			buf_q <= m_rdata_i;
	end

	always_comb begin
		case (state_q)
			ST_RD:   m_op_o = PI1_RD;
			ST_WR:   m_op_o = PI1_WR;
			default: m_op_o = PI1_NOP;
		endcase
	end

	assign m_addr_o  = (state_q == ST_WR) ? dst_q : src_q;
	assign m_wdata_o = buf_q;
	assign m_sel_o   = '1;

endmodule

// ==== design/gpio_port.sv ====
// ==================================================
// GPIO port
// Two-flop input synchronizer and an output register,
// both reachable as words of a bus slave.
// ==================================================
`timescale 1ns/10ps

module gpio_port import soc_pkg::*; #(
	parameter int GPIO_COUNT = 16
) (
	 input  logic                  clk100mhz_i
	,input  logic                  rst_p
	,input  pi1_op_t               op_i
	,input  addr_t                 addr_i
	,input  data_t                 wdata_i
	,output data_t                 rdata_o
	,output logic                  rdy_o
	,input  logic [GPIO_COUNT-1:0] gp_i
	,output logic [GPIO_COUNT-1:0] gp_o
);

	logic [GPIO_COUNT-1:0] sync1_q;
	logic [GPIO_COUNT-1:0] sync2_q;
	logic [GPIO_COUNT-1:0] out_q;
	data_t                 rdata_q;
	logic                  rdy_q;
	logic                  req;

	assign req = (op_i != PI1_NOP) && !rdy_q;

	// Inputs are asynchronous to the bus clock.
	always_ff @(posedge clk100mhz_i) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			rdy_q <= 1'b0;
			out_q <= '0;
		end else begin
			rdy_q <= req;
			// Byte selects do not apply here.
			if (req && op_i == PI1_WR && !addr_i[0])
				out_q <= wdata_i[GPIO_COUNT-1:0];
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (req && op_i == PI1_RD)
			rdata_q <= addr_i[0] ? data_t'(out_q) : data_t'(sync2_q);
	end

	assign rdata_o = rdata_q;
	assign rdy_o   = rdy_q;
	assign gp_o    = out_q;

endmodule

// ==== design/pi1_arbiter.sv ====
// ==================================================
// PI1 arbiter
// Grants the bus to the host or the DMA master,
// decodes the address into a slave region and hosts
// the invalid-device slave, which reads zero.
// ==================================================
`timescale 1ns/10ps

module pi1_arbiter import soc_pkg::*; (
	 input  logic    clk100mhz_i
	,input  logic    rst_p
	,input  pi1_op_t h_op_i
	,input  addr_t   h_addr_i
	,input  data_t   h_wdata_i
	,input  sel_t    h_sel_i
	,output data_t   h_rdata_o
	,output logic    h_rdy_o
	,input  pi1_op_t d_op_i
	,input  addr_t   d_addr_i
	,input  data_t   d_wdata_i
	,input  sel_t    d_sel_i
	,output data_t   d_rdata_o
	,output logic    d_rdy_o
	,output addr_t   s_addr_o
	,output data_t   s_wdata_o
	,output sel_t    s_sel_o
	,output pi1_op_t ram_op_o
	,output pi1_op_t dt_op_o
	,output pi1_op_t dma_op_o
	,output pi1_op_t gpio_op_o
	,input  data_t   ram_rdata_i
	,input  logic    ram_rdy_i
	,input  data_t   dt_rdata_i
	,input  logic    dt_rdy_i
	,input  data_t   dma_rdata_i
	,input  logic    dma_rdy_i
	,input  data_t   gpio_rdata_i
	,input  logic    gpio_rdy_i
);

	logic    busy_q;
	logic    gnt_q;
	logic    gnt_dma;
	pi1_op_t m_op;
	addr_t   m_addr;
	slave_e  slave_sel;
	addr_t   slave_base;
	data_t   sl_rdata;
	logic    sl_rdy;
	logic    bus_rdy;

	// Unsigned wrap makes a single compare cover both region bounds.
	function automatic logic in_region(input addr_t a, input addr_t base, input int words);
		in_region = (addr_t'(a - base) < addr_t'(words));
	endfunction

	// A running access keeps its master; otherwise the host wins.
	always_comb begin
		if (busy_q)
			gnt_dma = gnt_q;
		else
			gnt_dma = (h_op_i == PI1_NOP) && (d_op_i != PI1_NOP);
	end

	assign m_op      = gnt_dma ? d_op_i : h_op_i;
	assign m_addr    = gnt_dma ? d_addr_i : h_addr_i;
	assign s_wdata_o = gnt_dma ? d_wdata_i : h_wdata_i;
	assign s_sel_o   = gnt_dma ? d_sel_i : h_sel_i;

	always_comb begin
		slave_sel  = S_INVALID;
		slave_base = m_addr;
		if (in_region(m_addr, RAM_BASE, RAM_WORDS)) begin
			slave_sel  = S_RAM;
			slave_base = RAM_BASE;
		end else if (in_region(m_addr, DEVTBL_BASE, DEVTBL_WORDS)) begin
			slave_sel  = S_DEVTBL;
			slave_base = DEVTBL_BASE;
		end else if (in_region(m_addr, DMA_BASE, DMA_WORDS)) begin
			slave_sel  = S_DMA;
			slave_base = DMA_BASE;
		end else if (in_region(m_addr, GPIO_BASE, GPIO_WORDS)) begin
			slave_sel  = S_GPIO;
			slave_base = GPIO_BASE;
		end
	end

	assign s_addr_o = m_addr - slave_base;

	assign ram_op_o  = (slave_sel == S_RAM) ? m_op : PI1_NOP;
	assign dt_op_o   = (slave_sel == S_DEVTBL) ? m_op : PI1_NOP;
	assign dma_op_o  = (slave_sel == S_DMA) ? m_op : PI1_NOP;
	assign gpio_op_o = (slave_sel == S_GPIO) ? m_op : PI1_NOP;

	// Invalid device completes at once with zero data.
	always_comb begin
		case (slave_sel)
			S_RAM: begin
				sl_rdata = ram_rdata_i;
				sl_rdy   = ram_rdy_i;
			end
			S_DEVTBL: begin
				sl_rdata = dt_rdata_i;
				sl_rdy   = dt_rdy_i;
			end
			S_DMA: begin
				sl_rdata = dma_rdata_i;
				sl_rdy   = dma_rdy_i;
			end
			S_GPIO: begin
				sl_rdata = gpio_rdata_i;
				sl_rdy   = gpio_rdy_i;
			end
			default: begin
				sl_rdata = '0;
				sl_rdy   = 1'b1;
			end
		endcase
	end

	assign bus_rdy = (m_op != PI1_NOP) && sl_rdy;

	assign h_rdata_o = sl_rdata;
	assign d_rdata_o = sl_rdata;
	assign h_rdy_o   = bus_rdy && !gnt_dma;
	assign d_rdy_o   = bus_rdy && gnt_dma;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			busy_q <= 1'b0;
			gnt_q  <= 1'b0;
		end else if (!busy_q) begin
			if (m_op != PI1_NOP && !bus_rdy) begin
				busy_q <= 1'b1;
				gnt_q  <= gnt_dma;
			end
		end else if (bus_rdy) begin
			busy_q <= 1'b0;
		end
	end

endmodule

// ==== design/ram_slave.sv ====
// ==================================================
// On-chip RAM slave
// Word memory with byte-lane writes and a registered
// read, answering each request with one rdy pulse.
// ==================================================
`timescale 1ns/10ps

module ram_slave import soc_pkg::*; (
	 input  logic    clk100mhz_i
	,input  logic    rst_p
	,input  pi1_op_t op_i
	,input  addr_t   addr_i
	,input  data_t   wdata_i
	,input  sel_t    sel_i
	,output data_t   rdata_o
	,output logic    rdy_o
);

	localparam int IDX_BITS = $clog2(RAM_WORDS);

	data_t               mem [RAM_WORDS];
	data_t               rdata_q;
	logic                rdy_q;
	logic                req;
	logic [IDX_BITS-1:0] idx;

	assign req = (op_i != PI1_NOP) && !rdy_q;
	assign idx = addr_i[IDX_BITS-1:0];

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= req;
	end

	always_ff @(posedge clk100mhz_i) begin
		if (req && op_i == PI1_WR) begin
			for (int b = 0; b < SEL_BITS; b++) begin
				if (sel_i[b])
					mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
			end
		end
		if (req && op_i == PI1_RD)
			rdata_q <= mem[idx];
	end

	assign rdata_o = rdata_q;
	assign rdy_o   = rdy_q;

endmodule

// ==== design/soc_pkg.sv ====
// ==================================================
// SoC bus package
// Bus widths, pi1 op codes, slave indices, the
// address map and the device table contents.
// ==================================================

package soc_pkg;

	localparam int ARCH_BITS = 32;
	localparam int SEL_BITS  = ARCH_BITS / 8;
	localparam int ADDR_BITS = 30;

	typedef logic [ARCH_BITS-1:0] data_t;
	typedef logic [SEL_BITS-1:0]  sel_t;
	typedef logic [ADDR_BITS-1:0] addr_t;

	// Read-modify-write is not supported on this bus.
	typedef enum logic [1:0] {
		PI1_NOP = 2'd0,
		PI1_WR  = 2'd1,
		PI1_RD  = 2'd2
	} pi1_op_t;

	typedef enum logic [2:0] {
		S_RAM     = 3'd0,
		S_DEVTBL  = 3'd1,
		S_DMA     = 3'd2,
		S_GPIO    = 3'd3,
		S_INVALID = 3'd4
	} slave_e;

	localparam int SLAVE_COUNT = 5;

	// Word address map; every region spans a power of two words.
	localparam addr_t RAM_BASE      = 30'h000;
	localparam int    RAM_WORDS     = 1024;
	localparam addr_t DEVTBL_BASE   = 30'h400;
	localparam int    DEVTBL_WORDS  = 32;
	localparam addr_t DMA_BASE      = 30'h420;
	localparam int    DMA_WORDS     = 4;
	localparam addr_t GPIO_BASE     = 30'h424;
	localparam int    GPIO_WORDS    = 2;
	localparam int    INVALID_WORDS = 1024;

	function automatic data_t dev_id(input slave_e s);
		case (s)
			S_RAM:    dev_id = 32'd1;
			S_DEVTBL: dev_id = 32'd7;
			S_DMA:    dev_id = 32'd2;
			S_GPIO:   dev_id = 32'd6;
			default:  dev_id = 32'd0;
		endcase
	endfunction

	function automatic data_t dev_mapsz(input slave_e s);
		case (s)
			S_RAM:    dev_mapsz = data_t'(RAM_WORDS);
			S_DEVTBL: dev_mapsz = data_t'(DEVTBL_WORDS);
			S_DMA:    dev_mapsz = data_t'(DMA_WORDS);
			S_GPIO:   dev_mapsz = data_t'(GPIO_WORDS);
			default:  dev_mapsz = data_t'(INVALID_WORDS);
		endcase
	endfunction

endpackage

// ==== design/soc_top.sv ====
// ==================================================
// SoC top level
// Host master port and DMA engine sharing one pi1 bus
// with RAM, device table, GPIO and DMA registers.
// ==================================================
`timescale 1ns/10ps

module soc_top import soc_pkg::*; #(
	 parameter int GPIO_COUNT   = 16
	,parameter int DMA_LEN_BITS = 16
) (
	 input  logic                  clk100mhz_i
	,input  logic                  rst_p
	,input  pi1_op_t               host_op_i
	,input  addr_t                 host_addr_i
	,input  data_t                 host_wdata_i
	,input  sel_t                  host_sel_i
	,output data_t                 host_rdata_o
	,output logic                  host_rdy_o
	,input  logic [GPIO_COUNT-1:0] gp_i
	,output logic [GPIO_COUNT-1:0] gp_o
);

	// DMA master side.
	pi1_op_t d_op;
	addr_t   d_addr;
	data_t   d_wdata;
	sel_t    d_sel;
	data_t   d_rdata;
	logic    d_rdy;

	// Shared slave request lines.
	addr_t   s_addr;
	data_t   s_wdata;
	sel_t    s_sel;

	pi1_op_t ram_op;
	pi1_op_t dt_op;
	pi1_op_t dma_op;
	pi1_op_t gpio_op;
	data_t   ram_rdata;
	data_t   dt_rdata;
	data_t   dma_rdata;
	data_t   gpio_rdata;
	logic    ram_rdy;
	logic    dt_rdy;
	logic    dma_rdy;
	logic    gpio_rdy;

	pi1_arbiter u_arbiter (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.h_op_i      (host_op_i)
		,.h_addr_i    (host_addr_i)
		,.h_wdata_i   (host_wdata_i)
		,.h_sel_i     (host_sel_i)
		,.h_rdata_o   (host_rdata_o)
		,.h_rdy_o     (host_rdy_o)
		,.d_op_i      (d_op)
		,.d_addr_i    (d_addr)
		,.d_wdata_i   (d_wdata)
		,.d_sel_i     (d_sel)
		,.d_rdata_o   (d_rdata)
		,.d_rdy_o     (d_rdy)
		,.s_addr_o    (s_addr)
		,.s_wdata_o   (s_wdata)
		,.s_sel_o     (s_sel)
		,.ram_op_o    (ram_op)
		,.dt_op_o     (dt_op)
		,.dma_op_o    (dma_op)
		,.gpio_op_o   (gpio_op)
		,.ram_rdata_i (ram_rdata)
		,.ram_rdy_i   (ram_rdy)
		,.dt_rdata_i  (dt_rdata)
		,.dt_rdy_i    (dt_rdy)
		,.dma_rdata_i (dma_rdata)
		,.dma_rdy_i   (dma_rdy)
		,.gpio_rdata_i (gpio_rdata)
		,.gpio_rdy_i  (gpio_rdy)
	);

	dma_engine #(
		.DMA_LEN_BITS (DMA_LEN_BITS)
	) u_dma (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.s_op_i      (dma_op)
		,.s_addr_i    (s_addr)
		,.s_wdata_i   (s_wdata)
		,.s_rdata_o   (dma_rdata)
		,.s_rdy_o     (dma_rdy)
		,.m_op_o      (d_op)
		,.m_addr_o    (d_addr)
		,.m_wdata_o   (d_wdata)
		,.m_sel_o     (d_sel)
		,.m_rdata_i   (d_rdata)
		,.m_rdy_i     (d_rdy)
	);

	ram_slave u_ram (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.op_i        (ram_op)
		,.addr_i      (s_addr)
		,.wdata_i     (s_wdata)
		,.sel_i       (s_sel)
		,.rdata_o     (ram_rdata)
		,.rdy_o       (ram_rdy)
	);

	dev_table u_devtbl (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.op_i        (dt_op)
		,.addr_i      (s_addr)
		,.rdata_o     (dt_rdata)
		,.rdy_o       (dt_rdy)
	);

	gpio_port #(
		.GPIO_COUNT (GPIO_COUNT)
	) u_gpio (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.op_i        (gpio_op)
		,.addr_i      (s_addr)
		,.wdata_i     (s_wdata)
		,.rdata_o     (gpio_rdata)
		,.rdy_o       (gpio_rdy)
		,.gp_i        (gp_i)
		,.gp_o        (gp_o)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the SoC testbench with Verilator and run it.
# Exit status is 0 only when the run reports a pass.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_soc -f verilog.f -o tb_soc &&
out="$(./obj_dir/tb_soc)" || { echo "Build or simulation run failed"; exit 1; }
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^TB PASSED$" && exit 0 || exit 1

// ==== tests/tb_soc.sv ====
// ==================================================
// SoC testbench
// Drives the host port through RAM, device table,
// GPIO, invalid-region and DMA copy scenarios and
// checks every response against reference models.
// ==================================================
`timescale 1ns/10ps

module tb_soc import soc_pkg::*; ();

	localparam int    GPIO_COUNT = 16;
	localparam int    WAIT_LIMIT = 200;
	localparam int    FILL_WORDS = 64;
	localparam addr_t COPY_SRC   = 30'h100;
	localparam addr_t COPY_DST   = 30'h200;
	localparam int    COPY_LEN   = 20;

	logic                  clk100mhz_i;
	logic                  rst_p;
	pi1_op_t               host_op_i;
	addr_t                 host_addr_i;
	data_t                 host_wdata_i;
	sel_t                  host_sel_i;
	data_t                 host_rdata_o;
	logic                  host_rdy_o;
	logic [GPIO_COUNT-1:0] gp_i;
	logic [GPIO_COUNT-1:0] gp_o;

	// Shadow copy of the on-chip RAM.
	data_t shadow_mem [RAM_WORDS];

	int error_count;
	int check_count;
	int timeout_count;
	int test_count;
	int test_fail_count;
	int test_err_base;
	int last_wait;

	soc_top #(
		 .GPIO_COUNT   (GPIO_COUNT)
		,.DMA_LEN_BITS (16)
	) u_dut (
		 .clk100mhz_i  (clk100mhz_i)
		,.rst_p        (rst_p)
		,.host_op_i    (host_op_i)
		,.host_addr_i  (host_addr_i)
		,.host_wdata_i (host_wdata_i)
		,.host_sel_i   (host_sel_i)
		,.host_rdata_o (host_rdata_o)
		,.host_rdy_o   (host_rdy_o)
		,.gp_i         (gp_i)
		,.gp_o         (gp_o)
	);

	initial begin
		clk100mhz_i = 1'b0;
		forever #5 clk100mhz_i = ~clk100mhz_i;
	end

	// Byte-lane merge of a write into an old RAM word.
	function automatic data_t ref_ram(input data_t old, input data_t wdata, input sel_t sel);
		data_t merged;
		merged = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				merged[b*8 +: 8] = wdata[b*8 +: 8];
		end
		return merged;
	endfunction

	// Id on even words, map size on odd words.
	function automatic data_t ref_devtbl(input int word);
		case (word)
			0:       return 32'd1;
			1:       return 32'd1024;
			2:       return 32'd7;
			3:       return 32'd32;
			4:       return 32'd2;
			5:       return 32'd4;
			6:       return 32'd6;
			7:       return 32'd2;
			8:       return 32'd0;
			9:       return 32'd1024;
			default: return 32'd0;
		endcase
	endfunction

	function automatic void ref_dma(input addr_t src, input addr_t dst, input int len);
		for (int i = 0; i < len; i++)
			shadow_mem[dst + i] = shadow_mem[src + i];
	endfunction

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t ns %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	// One pi1 access; op is held until rdy, then back to no-op.
	task automatic host_access(input pi1_op_t op, input addr_t addr, input data_t wdata,
			input sel_t sel, output data_t rdata);
		bit done;
		@(posedge clk100mhz_i);
		host_op_i    <= op;
		host_addr_i  <= addr;
		host_wdata_i <= wdata;
		host_sel_i   <= sel;
		done      = 1'b0;
		last_wait = 0;
		rdata     = '0;
		while (!done && last_wait < WAIT_LIMIT) begin
			@(negedge clk100mhz_i);
			if (host_rdy_o) begin
				done  = 1'b1;
				rdata = host_rdata_o;
			end else begin
				last_wait++;
			end
		end
		if (!done) begin
			error_count++;
			timeout_count++;
			$display("Host access to address %h got no ready within %0d cycles",
				addr, WAIT_LIMIT);
		end
		@(posedge clk100mhz_i);
		host_op_i <= PI1_NOP;
	endtask

	task automatic host_write(input addr_t addr, input data_t wdata, input sel_t sel);
		data_t unused;
		host_access(PI1_WR, addr, wdata, sel, unused);
	endtask

	task automatic host_read(input addr_t addr, output data_t rdata);
		host_access(PI1_RD, addr, '0, '0, rdata);
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = error_count - test_err_base;
		test_count++;
		if (errs == 0) begin
			$display("Test %0d %s: ok", test_count, name);
		end else begin
			test_fail_count++;
			$display("Test %0d %s: %0d error(s)", test_count, name, errs);
		end
		test_err_base = error_count;
	endtask

	initial begin
		data_t                 rd;
		data_t                 wd;
		sel_t                  sel;
		addr_t                 a;
		logic [GPIO_COUNT-1:0] gval;
		int                    polls;
		void'($urandom(26));
		error_count     = 0;
		check_count     = 0;
		timeout_count   = 0;
		test_count      = 0;
		test_fail_count = 0;
		test_err_base   = 0;
		last_wait       = 0;
		rst_p        <= 1'b1;
		host_op_i    <= PI1_NOP;
		host_addr_i  <= '0;
		host_wdata_i <= '0;
		host_sel_i   <= '0;
		gp_i         <= '0;
		repeat (8) @(posedge clk100mhz_i);
		rst_p <= 1'b0;

		@(negedge clk100mhz_i);
		check_flag("host_rdy_o", 1'b0, host_rdy_o);
		check_data("gp_o", '0, data_t'(gp_o));
		host_read(DMA_BASE + 30'd3, rd);
		check_data("dma status", '0, rd);
		finish_test("reset state");

		// Full words first, so every byte of the range is known.
		for (int i = 0; i < FILL_WORDS; i++) begin
			wd = $urandom;
			host_write(addr_t'(i), wd, 4'hF);
			shadow_mem[i] = wd;
		end
		for (int i = 0; i < 40; i++) begin
			a   = addr_t'($urandom_range(FILL_WORDS - 1));
			wd  = $urandom;
			sel = sel_t'($urandom);
			host_write(a, wd, sel);
			shadow_mem[a] = ref_ram(shadow_mem[a], wd, sel);
		end
		for (int i = 0; i < FILL_WORDS; i++) begin
			host_read(addr_t'(i), rd);
			check_data($sformatf("host_rdata_o ram[%0d]", i), shadow_mem[i], rd);
			check_flag("host_rdy_o ram latency", 1'b1, last_wait == 1);
		end
		finish_test("ram byte-select writes");

		for (int w = 0; w < DEVTBL_WORDS; w++) begin
			host_read(DEVTBL_BASE + addr_t'(w), rd);
			check_data($sformatf("host_rdata_o devtbl[%0d]", w), ref_devtbl(w), rd);
			check_flag("host_rdy_o devtbl latency", 1'b1, last_wait == 1);
		end
		host_write(DEVTBL_BASE, 32'hFFFF_FFFF, 4'hF);
		host_read(DEVTBL_BASE, rd);
		check_data("host_rdata_o devtbl[0] after write", ref_devtbl(0), rd);
		finish_test("device table");

		gval = GPIO_COUNT'($urandom);
		@(posedge clk100mhz_i);
		gp_i <= gval;
		repeat (4) @(posedge clk100mhz_i);
		host_read(GPIO_BASE, rd);
		check_data("host_rdata_o gpio in", data_t'(gval), rd);
		wd = $urandom;
		host_write(GPIO_BASE, wd, 4'h1);
		check_data("gp_o", data_t'(wd[GPIO_COUNT-1:0]), data_t'(gp_o));
		host_read(GPIO_BASE + 30'd1, rd);
		check_data("host_rdata_o gpio out", data_t'(wd[GPIO_COUNT-1:0]), rd);
		finish_test("gpio");

		gval = gp_o;
		for (int i = 0; i < 3; i++) begin
			case (i)
				0:       a = 30'h426;
				1:       a = 30'h800;
				default: a = 30'h3FFF_FFFF;
			endcase
			host_read(a, rd);
			check_data($sformatf("host_rdata_o invalid %h", a), '0, rd);
			check_flag("host_rdy_o same cycle", 1'b1, last_wait == 0);
			host_write(a, $urandom, 4'hF);
			host_read(a, rd);
			check_data($sformatf("host_rdata_o invalid %h", a), '0, rd);
		end
		check_data("gp_o", data_t'(gval), data_t'(gp_o));
		for (int i = 0; i < FILL_WORDS; i++) begin
			host_read(addr_t'(i), rd);
			check_data($sformatf("host_rdata_o ram[%0d]", i), shadow_mem[i], rd);
		end
		finish_test("invalid region");

		for (int i = 0; i < COPY_LEN; i++) begin
			wd = $urandom;
			host_write(COPY_SRC + addr_t'(i), wd, 4'hF);
			shadow_mem[COPY_SRC + i] = wd;
		end
		host_write(DMA_BASE, data_t'(COPY_SRC), 4'hF);
		host_write(DMA_BASE + 30'd1, data_t'(COPY_DST), 4'hF);
		host_read(DMA_BASE, rd);
		check_data("dma src reg", data_t'(COPY_SRC), rd);
		host_read(DMA_BASE + 30'd1, rd);
		check_data("dma dst reg", data_t'(COPY_DST), rd);
		host_write(DMA_BASE + 30'd2, data_t'(COPY_LEN), 4'hF);
		host_read(DMA_BASE + 30'd3, rd);
		check_flag("dma busy", 1'b1, rd[0]);
		// Ignored while the copy runs.
		host_write(DMA_BASE, 32'h0000_0300, 4'hF);
		for (int i = 0; i < 8; i++) begin
			a = addr_t'($urandom_range(FILL_WORDS - 1));
			host_read(a, rd);
			check_data($sformatf("host_rdata_o ram[%0d] during copy", a), shadow_mem[a], rd);
		end
		polls = 0;
		rd    = 32'd1;
		while (rd[0] !== 1'b0 && polls < WAIT_LIMIT) begin
			host_read(DMA_BASE + 30'd3, rd);
			polls++;
		end
		if (rd[0] !== 1'b0) begin
			error_count++;
			$display("DMA copy still busy after %0d status polls", polls);
		end else begin
			check_data("dma status", '0, rd);
		end
		ref_dma(COPY_SRC, COPY_DST, COPY_LEN);
		for (int i = 0; i < COPY_LEN; i++) begin
			host_read(COPY_DST + addr_t'(i), rd);
			check_data($sformatf("host_rdata_o dst[%0d]", i), shadow_mem[COPY_DST + i], rd);
			host_read(COPY_SRC + addr_t'(i), rd);
			check_data($sformatf("host_rdata_o src[%0d]", i), shadow_mem[COPY_SRC + i], rd);
		end
		host_read(DMA_BASE, rd);
		check_data("dma src reg", data_t'(COPY_SRC + COPY_LEN), rd);
		host_read(DMA_BASE + 30'd1, rd);
		check_data("dma dst reg", data_t'(COPY_DST + COPY_LEN), rd);
		finish_test("dma copy");

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d timeouts",
			test_count, test_fail_count, check_count, error_count, timeout_count);
		if (error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
design/soc_pkg.sv
design/pi1_arbiter.sv
design/dma_engine.sv
design/ram_slave.sv
design/gpio_port.sv
design/dev_table.sv
design/soc_top.sv
tests/tb_soc.sv
